//--- build.f
src/harness_cfg_pkg.sv
src/harness_types_pkg.sv
src/harness_ctrl_if.sv
src/capture_buf.sv
src/harness_regs.sv
src/pattern_sequencer.sv
src/read_checker.sv
src/dram_test_harness.sv
verification/ddr_model.sv
verification/harness_checker.sv
verification/tb_dram_harness.sv

//--- Makefile
# Verilator build and run for the DRAM test harness

VERILATOR ?= verilator
FILELIST  ?= build.f
TOP       ?= tb_dram_harness
RTL_TOP   ?= dram_test_harness
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_dram_harness.sv
// DRAM test harness testbench: table of runs driven over the register bus
module tb_dram_harness;
  import harness_cfg_pkg::*;

  localparam int N_TESTS = 4;
  localparam int MAX_CORR = 6;

  // Size, corrupted beats (ascending), read-block base, forced stall
  int t_size  [N_TESTS] = '{8, 12, 16, 10};
  int t_ncorr [N_TESTS] = '{0, 2, 6, 0};
  int t_corr  [N_TESTS][MAX_CORR] = '{'{0, 0, 0, 0, 0, 0}, '{5, 9, 0, 0, 0, 0},
                                      '{1, 3, 7, 10, 20, 30}, '{0, 0, 0, 0, 0, 0}};
  int t_base  [N_TESTS] = '{3, 4, 0, 6};
  int t_stall [N_TESTS] = '{0, 0, 0, 30};

  logic        clk;
  logic        module_rst;
  logic        reg_req_i;
  logic        reg_we_i;
  logic [5:0]  reg_addr_i;
  logic [15:0] reg_wdata_i;
  logic        reg_ack_o;
  logic [15:0] reg_rdata_o;
  logic        ddr_rd_wr_n_o;
  logic [15:0] ddr_addr_o;
  logic [31:0] ddr_data_o;
  logic        ddr_af_we_o;
  logic        ddr_df_we_o;
  logic        ddr_af_afull_i;
  logic        ddr_df_afull_i;
  logic [31:0] ddr_data_i;
  logic        ddr_dvalid_i;
  logic        ddr_phy_rdy_i;
  int          cycles = 0;
  int          limit = 0;
  int          failed_tests = 0;

  dram_test_harness i_dram_test_harness (.*);

  ddr_model i_ddr_model (
    .clk        (clk),
    .module_rst (module_rst),
    .af_we_i    (ddr_af_we_o),
    .df_we_i    (ddr_df_we_o),
    .rd_wr_n_i  (ddr_rd_wr_n_o),
    .addr_i     (ddr_addr_o),
    .wdata_i    (ddr_data_o),
    .af_afull_o (ddr_af_afull_i),
    .df_afull_o (ddr_df_afull_i),
    .data_o     (ddr_data_i),
    .dvalid_o   (ddr_dvalid_i)
  );

  harness_checker i_harness_checker (
    .clk         (clk),
    .reg_we_i    (reg_we_i),
    .reg_ack_i   (reg_ack_o),
    .reg_rdata_i (reg_rdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if ((limit > 0) && (cycles >= limit)) begin
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Four-phase transfer entered and left 2 units after a rising edge
  task automatic bus_xfer(input logic we, input logic [5:0] addr, input logic [15:0] wdata,
                          output logic [15:0] rdata);
    reg_req_i   = 1'b1;
    reg_we_i    = we;
    reg_addr_i  = addr;
    reg_wdata_i = wdata;
    do @(negedge clk); while (!reg_ack_o);
    rdata = reg_rdata_o;
    @(posedge clk);
    #2 reg_req_i = 1'b0;
    do @(negedge clk); while (reg_ack_o);
    @(posedge clk);
    #2;
  endtask

  task automatic reg_write(input logic [5:0] addr, input int value);
    logic [15:0] unused;
    bus_xfer(1'b1, addr, 16'(value), unused);
  endtask

  task automatic reg_check(input string name, input logic [5:0] addr, input int value);
    logic [15:0] unused;
    i_harness_checker.expect_read(name, 16'(value));
    bus_xfer(1'b0, addr, 16'h0, unused);
  endtask

  function automatic bit is_corrupt(input int t, input int beat);
    for (int j = 0; j < t_ncorr[t]; j++) begin
      if (t_corr[t][j] == beat) return 1'b1;
    end
    return 1'b0;
  endfunction

  // Beat index in both halves with bits 23:16 flipped on a corrupted beat
  function automatic logic [31:0] beat_value(input int t, input int beat);
    logic [31:0] v;
    v = {16'(beat), 16'(beat)};
    if (is_corrupt(t, beat)) v = v ^ 32'h00ff0000;
    return v;
  endfunction

  task automatic run_test(input int t);
    logic [15:0] st;
    logic [31:0] v;
    int          nrec;
    int          err0;
    err0 = i_harness_checker.err_cnt;
    i_ddr_model.configure(t_stall[t]);
    for (int j = 0; j < t_ncorr[t]; j++) begin
      i_ddr_model.mark_corrupt(t_corr[t][j]);
    end
    reg_write(REG_SIZE, t_size[t]);
    reg_write(REG_RDBLK, t_base[t]);
    reg_write(REG_CTRL, 0);
    reg_write(REG_CTRL, 1);
    do bus_xfer(1'b0, REG_STATUS, 16'h0, st); while (!st[0]);
    reg_check("SIZE", REG_SIZE, t_size[t]);
    reg_check("RDBLK", REG_RDBLK, t_base[t]);
    reg_check("CTRL", REG_CTRL, 1);
    reg_check("STATUS", REG_STATUS,
              1 + ((t_ncorr[t] > 0) ? 2 : 0) + ((t_stall[t] > 0) ? 4 : 0));
    nrec = (t_ncorr[t] < FAULT_DEPTH) ? t_ncorr[t] : FAULT_DEPTH;
    reg_check("FAULT_CNT", REG_FAULT_CNT, nrec);
    reg_check("AFULL_ADDR", REG_AFULL_ADDR, 0);  // Stall begins with the write to address 0
    for (int n = 0; n < nrec; n++) begin
      v = beat_value(t, t_corr[t][n]);
      reg_check("FAULT_DATA_LO", 6'(8 + 3 * n), int'(v[15:0]));
      reg_check("FAULT_DATA_HI", 6'(9 + 3 * n), int'(v[31:16]));
      reg_check("FAULT_BEAT", 6'(10 + 3 * n), t_corr[t][n]);
    end
    for (int j = 0; j < RDBLK_DEPTH; j++) begin
      v = beat_value(t, t_base[t] + j);
      reg_check("RDBLK_LO", 6'(20 + 2 * j), int'(v[15:0]));
      reg_check("RDBLK_HI", 6'(21 + 2 * j), int'(v[31:16]));
    end
    reg_write(REG_CTRL, 2);  // Soft reset
    reg_check("STATUS", REG_STATUS, 0);
    if (i_harness_checker.err_cnt == err0) begin
      $display("Test %0d size %0d faults %0d stall %0d: ok", t, t_size[t], t_ncorr[t],
               t_stall[t]);
    end else begin
      failed_tests++;
      $display("Test %0d size %0d: %0d errors", t, t_size[t],
               i_harness_checker.err_cnt - err0);
    end
  endtask

  initial begin
    module_rst    = 1'b1;
    reg_req_i     = 1'b0;
    reg_we_i      = 1'b0;
    reg_addr_i    = '0;
    reg_wdata_i   = '0;
    ddr_phy_rdy_i = 1'b1;
    for (int t = 0; t < N_TESTS; t++) begin
      limit += 8 * t_size[t] + 200;
    end
    repeat (3) @(posedge clk);
    #2 module_rst = 1'b0;
    for (int t = 0; t < N_TESTS; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors", N_TESTS, failed_tests,
             i_harness_checker.chk_cnt, i_harness_checker.err_cnt);
    if ((failed_tests == 0) && (i_harness_checker.err_cnt == 0) &&
        (i_ddr_model.overflow_cnt == 0)) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- verification/harness_checker.sv
// Register read checker: compares each acknowledged read with the value the test expects
module harness_checker (
  input  logic        clk,
  input  logic        reg_we_i,
  input  logic        reg_ack_i,
  input  logic [15:0] reg_rdata_i
);
  string       name_q [$];
  logic [15:0] exp_q [$];
  logic        ack_q = 1'b0;
  int          err_cnt = 0;
  int          chk_cnt = 0;

  // Queues one expected value for the next read
  task automatic expect_read(input string name, input logic [15:0] value);
    name_q.push_back(name);
    exp_q.push_back(value);
  endtask

  // Sampled away from the rising edge, ack and read data are settled here
  always @(negedge clk) begin : compare
    string       nm;
    logic [15:0] ev;
    if (reg_ack_i && !ack_q && !reg_we_i && (exp_q.size() > 0)) begin
      nm = name_q.pop_front();
      ev = exp_q.pop_front();
      chk_cnt++;
      if (reg_rdata_i !== ev) begin
        err_cnt++;
        $display("ERR %s: got 0x%04h expected 0x%04h", nm, reg_rdata_i, ev);
      end
    end
    ack_q <= reg_ack_i;
  end

endmodule

//--- verification/ddr_model.sv
// DRAM controller model: address/data fifos, almost-full, delayed in-order read return
module ddr_model (
  input  logic        clk,
  input  logic        module_rst,
  input  logic        af_we_i,
  input  logic        df_we_i,
  input  logic        rd_wr_n_i,
  input  logic [15:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic        af_afull_o,
  output logic        df_afull_o,
  output logic [31:0] data_o,
  output logic        dvalid_o
);
  localparam int FIFO_DEPTH = 8;
  localparam int AFULL_LVL  = 6;

  logic [31:0] mem [0:511];  // Two beats per address
  logic        corrupt [0:511];
  int          af_cnt;
  int          df_cnt;
  int          stall_left;
  bit          armed;
  int          cyc;
  int          last_due;
  int          due_q [$];
  int          idx_q [$];
  int          overflow_cnt = 0;  // Cycles with a fifo beyond its depth
  logic [31:0] rng = 32'h20e5;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Clears the corruption list and arms a forced stall for the next run
  task automatic configure(input int stall_cycles);
    for (int i = 0; i < 512; i++) begin
      corrupt[i] = 1'b0;
    end
    stall_left = stall_cycles;
    armed      = 1'b0;
  endtask

  task automatic mark_corrupt(input int beat);
    corrupt[beat] = 1'b1;
  endtask

  initial begin
    af_afull_o = 1'b0;
    df_afull_o = 1'b0;
    data_o     = '0;
    dvalid_o   = 1'b0;
    configure(0);
  end

  always @(posedge clk) begin : model_step
    logic stalling;
    int   due;
    int   idx;
    #2;
    if (module_rst) begin
      af_cnt   = 0;
      df_cnt   = 0;
      cyc      = 0;
      last_due = 0;
      due_q.delete();
      idx_q.delete();
      dvalid_o   = 1'b0;
      af_afull_o = 1'b0;
      df_afull_o = 1'b0;
    end else begin
      cyc++;
      if (df_we_i) begin
        armed = 1'b1;  // Stall starts with the first write beat
        df_cnt++;
        mem[{addr_i[7:0], ~af_we_i}] = wdata_i;  // Command cycle carries beat 0
      end
      if (af_we_i) begin
        af_cnt++;
      end
      if ((af_cnt > FIFO_DEPTH) || (df_cnt > FIFO_DEPTH)) begin
        if (overflow_cnt == 0) begin
          $display("Fifo overflow: a write was accepted while the model fifo was full");
        end
        overflow_cnt++;
      end
      if (af_we_i && rd_wr_n_i) begin
        rng = xorshift(rng);
        due = cyc + 2 + int'(rng % 8);
        if (due <= last_due) due = last_due + 1;
        due_q.push_back(due);
        idx_q.push_back(int'({addr_i[7:0], 1'b0}));
        due_q.push_back(due + 1);
        idx_q.push_back(int'({addr_i[7:0], 1'b1}));
        last_due = due + 1;
      end
      stalling = armed && (stall_left > 0);
      if (stalling) begin
        stall_left--;
      end else begin
        if (af_cnt > 0) af_cnt--;
        if (df_cnt > 0) df_cnt--;
      end
      af_afull_o = stalling || (af_cnt >= AFULL_LVL);
      df_afull_o = df_cnt >= AFULL_LVL;
      dvalid_o   = 1'b0;
      if ((due_q.size() > 0) && (due_q[0] <= cyc)) begin
        void'(due_q.pop_front());
        idx      = idx_q.pop_front();
        data_o   = mem[idx] ^ (corrupt[idx] ? 32'h00ff0000 : 32'h0);
        dvalid_o = 1'b1;
      end
    end
  end

endmodule

//--- src/dram_test_harness.sv
// DRAM controller test harness top: register bus, pattern sequencer and read checker
module dram_test_harness (
  input  logic                                  clk,
  input  logic                                  module_rst,
  input  logic                                  reg_req_i,
  input  logic                                  reg_we_i,
  input  logic [harness_cfg_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [harness_cfg_pkg::REG_W-1:0]      reg_wdata_i,
  output logic                                  reg_ack_o,
  output logic [harness_cfg_pkg::REG_W-1:0]      reg_rdata_o,
  output logic                                  ddr_rd_wr_n_o,
  output logic [harness_cfg_pkg::ADDR_W-1:0]     ddr_addr_o,
  output logic [harness_cfg_pkg::DATA_W-1:0]     ddr_data_o,
  output logic                                  ddr_af_we_o,
  output logic                                  ddr_df_we_o,
  input  logic                                  ddr_af_afull_i,
  input  logic                                  ddr_df_afull_i,
  input  logic [harness_cfg_pkg::DATA_W-1:0]     ddr_data_i,
  input  logic                                  ddr_dvalid_i,
  input  logic                                  ddr_phy_rdy_i
);

  harness_ctrl_if ctrl_if ();

  harness_regs i_harness_regs (
    .clk         (clk),
    .module_rst  (module_rst),
    .reg_req_i   (reg_req_i),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_ack_o   (reg_ack_o),
    .reg_rdata_o (reg_rdata_o),
    .ctrl        (ctrl_if.regs)
  );

  pattern_sequencer i_pattern_sequencer (
    .clk            (clk),
    .module_rst     (module_rst),
    .ddr_af_afull_i (ddr_af_afull_i),
    .ddr_df_afull_i (ddr_df_afull_i),
    .ddr_phy_rdy_i  (ddr_phy_rdy_i),
    .ddr_rd_wr_n_o  (ddr_rd_wr_n_o),
    .ddr_addr_o     (ddr_addr_o),
    .ddr_data_o     (ddr_data_o),
    .ddr_af_we_o    (ddr_af_we_o),
    .ddr_df_we_o    (ddr_df_we_o),
    .ctrl           (ctrl_if.seq)
  );

  read_checker i_read_checker (
    .clk           (clk),
    .module_rst    (module_rst),
    .ddr_phy_rdy_i (ddr_phy_rdy_i),
    .ddr_data_i    (ddr_data_i),
    .ddr_dvalid_i  (ddr_dvalid_i),
    .ctrl          (ctrl_if.chk)
  );

endmodule

//--- src/read_checker.sv
// Read checker: compares returned beats with the pattern, logs faults, captures the read block
module read_checker (
  input  logic                              clk,
  input  logic                              module_rst,
  input  logic                              ddr_phy_rdy_i,
  input  logic [harness_cfg_pkg::DATA_W-1:0] ddr_data_i,
  input  logic                              ddr_dvalid_i,
  harness_ctrl_if.chk                       ctrl
);
  import harness_cfg_pkg::*;
  import harness_types_pkg::*;

  logic                               rst_all;
  logic                               clear_cap;
  logic [BEAT_CNT_W-1:0]              beat_cnt;  // Index of the next beat expected
  logic [BEAT_CNT_W-1:0]              win_lo;
  logic [BEAT_CNT_W-1:0]              win_hi;
  logic                               mismatch;
  logic                               in_window;
  fault_rec_t                         fault_in;
  rdblk_rec_t                         rdblk_in;
  logic [$clog2(RDBLK_DEPTH+1)-1:0]   rdblk_cnt;

  assign rst_all   = module_rst | ctrl.soft_rst | ~ddr_phy_rdy_i;
  assign clear_cap = rst_all | ctrl.start;

  assign mismatch  = ddr_data_i != {beat_cnt[BEAT_W-1:0], beat_cnt[BEAT_W-1:0]};
  assign win_lo    = {1'b0, ctrl.rdblk_base};
  assign win_hi    = win_lo + BEAT_CNT_W'(RDBLK_DEPTH);
  assign in_window = (beat_cnt >= win_lo) && (beat_cnt < win_hi);

  assign fault_in.data     = ddr_data_i;
  assign fault_in.beat_idx = beat_cnt[BEAT_W-1:0];
  assign rdblk_in.data     = ddr_data_i;

  always_ff @(posedge clk) begin
    if (clear_cap) begin
      beat_cnt   <= '0;
      ctrl.done  <= 1'b0;
      ctrl.fault <= 1'b0;
    end else begin
      if (ddr_dvalid_i) begin
        beat_cnt <= beat_cnt + 1'b1;
        if (mismatch) begin
          ctrl.fault <= 1'b1;
        end
      end
      if (ctrl.busy_rd && (beat_cnt == {ctrl.test_size, 1'b0})) begin
        ctrl.done <= 1'b1;  // Every issued beat is back
      end
    end
  end

  // Fault log, its count is the fault counter
  capture_buf #(.entry_t(fault_rec_t), .DEPTH(FAULT_DEPTH)) i_fault_log (
    .clk      (clk),
    .clear_i  (clear_cap),
    .wr_i     (ddr_dvalid_i & mismatch),
    .entry_i  (fault_in),
    .rd_idx_i (ctrl.rec_idx),
    .entry_o  (ctrl.fault_rec),
    .count_o  (ctrl.fault_cnt)
  );

  capture_buf #(.entry_t(rdblk_rec_t), .DEPTH(RDBLK_DEPTH)) i_rdblk (
    .clk      (clk),
    .clear_i  (clear_cap),
    .wr_i     (ddr_dvalid_i & in_window),
    .entry_i  (rdblk_in),
    .rd_idx_i (ctrl.rec_idx),
    .entry_o  (ctrl.rdblk_rec),
    .count_o  (rdblk_cnt)
  );

  a_dvalid_in_read: assert property (@(posedge clk) disable iff (rst_all)
    ddr_dvalid_i |-> ctrl.busy_rd);

  // A window that lies inside the test is complete once done rises
  a_rdblk_full: assert property (@(posedge clk) disable iff (rst_all)
    $rose(ctrl.done) && (win_hi <= {ctrl.test_size, 1'b0})
      |-> rdblk_cnt == ($clog2(RDBLK_DEPTH+1))'(RDBLK_DEPTH));

endmodule

//--- src/pattern_sequencer.sv
// Test sequencer: writes the counting pattern, issues reads back, honours fifo almost-full
module pattern_sequencer (
  input  logic                              clk,
  input  logic                              module_rst,
  input  logic                              ddr_af_afull_i,
  input  logic                              ddr_df_afull_i,
  input  logic                              ddr_phy_rdy_i,
  output logic                              ddr_rd_wr_n_o,
  output logic [harness_cfg_pkg::ADDR_W-1:0] ddr_addr_o,
  output logic [harness_cfg_pkg::DATA_W-1:0] ddr_data_o,
  output logic                              ddr_af_we_o,
  output logic                              ddr_df_we_o,
  harness_ctrl_if.seq                       ctrl
);
  import harness_cfg_pkg::*;
  import harness_types_pkg::*;

  seq_state_t        state;
  logic [ADDR_W-1:0] addr;
  logic [BEAT_W-1:0] beat_idx;  // Write beat index
  logic              rst_all;
  logic              afull;
  logic              last_addr;

  assign rst_all   = module_rst | ctrl.soft_rst | ~ddr_phy_rdy_i;
  assign afull     = ddr_af_afull_i | ddr_df_afull_i;
  assign last_addr = (addr == ctrl.test_size - 1'b1);

  always_ff @(posedge clk) begin
    if (rst_all) begin
      state    <= IDLE;
      addr     <= '0;
      beat_idx <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (ctrl.start) begin
            addr     <= '0;
            beat_idx <= '0;
            state    <= WR_BEAT0;
          end
        end
        WR_BEAT0: begin
          beat_idx <= beat_idx + 1'b1;
          state    <= WR_BEAT1;
        end
        WR_BEAT1: begin
          beat_idx <= beat_idx + 1'b1;
          if (last_addr) begin
            state <= TURNAROUND;
          end else begin
            addr  <= addr + 1'b1;
            state <= afull ? WR_BACKOFF : WR_BEAT0;  // Flag checked once per address
          end
        end
        WR_BACKOFF: begin
          if (!afull) begin
            state <= WR_BEAT0;
          end
        end
        TURNAROUND: begin
          addr  <= '0;
          state <= RD_ISSUE;
        end
        RD_ISSUE: begin
          if (last_addr) begin
            state <= WAIT_DATA;
          end else begin
            addr <= addr + 1'b1;
            if (afull) begin
              state <= RD_BACKOFF;
            end
          end
        end
        RD_BACKOFF: begin
          if (!afull) begin
            state <= RD_ISSUE;
          end
        end
        WAIT_DATA: begin
          if (ctrl.done) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // First almost-full of a run and the address in flight at that point
  always_ff @(posedge clk) begin
    if (rst_all) begin
      ctrl.afull_event <= 1'b0;
      ctrl.afull_addr  <= '0;
    end else if (ctrl.start) begin
      ctrl.afull_event <= 1'b0;
    end else if (afull && (state != IDLE) && !ctrl.afull_event) begin
      ctrl.afull_event <= 1'b1;
      ctrl.afull_addr  <= addr;
    end
  end

  assign ctrl.busy_rd  = (state == RD_ISSUE) || (state == RD_BACKOFF) || (state == WAIT_DATA);

  assign ddr_af_we_o   = (state == WR_BEAT0) || (state == RD_ISSUE);
  assign ddr_df_we_o   = (state == WR_BEAT0) || (state == WR_BEAT1);
  assign ddr_rd_wr_n_o = (state != WR_BEAT0);  // Sampled with ddr_af_we_o only
  assign ddr_addr_o    = addr;
  assign ddr_data_o    = {beat_idx, beat_idx};

  a_no_write_in_read: assert property (@(posedge clk) disable iff (rst_all)
    ctrl.busy_rd |-> !(ddr_af_we_o && ddr_df_we_o));

endmodule

//--- src/harness_regs.sv
// Register-bus slave: control registers, start/reset pulses and status/capture readback
module harness_regs (
  input  logic                                  clk,
  input  logic                                  module_rst,
  input  logic                                  reg_req_i,
  input  logic                                  reg_we_i,
  input  logic [harness_cfg_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [harness_cfg_pkg::REG_W-1:0]      reg_wdata_i,
  output logic                                  reg_ack_o,
  output logic [harness_cfg_pkg::REG_W-1:0]      reg_rdata_o,
  harness_ctrl_if.regs                          ctrl
);
  import harness_cfg_pkg::*;

  logic [REG_W-1:0]      ctrl_q;
  logic [REG_W-1:0]      size_q;
  logic [REG_W-1:0]      rdblk_q;
  logic [1:0]            ctrl_prev;   // CTRL pulse bits one cycle back
  logic                  req_new;
  logic [REG_ADDR_W-1:0] fault_off;
  logic [REG_ADDR_W-1:0] fault_num;
  logic [REG_ADDR_W-1:0] fault_word;
  logic [REG_ADDR_W-1:0] rdblk_off;
  logic [REG_ADDR_W-1:0] rdblk_num;
  logic [REG_ADDR_W-1:0] rdblk_word;
  logic                  in_fault;
  logic                  in_rdblk;
  logic [REG_W-1:0]      rd_mux;

  assign req_new = reg_req_i & ~reg_ack_o;  // Accepted once per request

  always_ff @(posedge clk) begin
    if (module_rst) begin
      reg_ack_o <= 1'b0;
      ctrl_q    <= '0;
      size_q    <= '0;
      rdblk_q   <= '0;
    end else if (req_new) begin
      reg_ack_o <= 1'b1;
      if (reg_we_i) begin
        case (reg_addr_i)
          REG_CTRL:  ctrl_q  <= reg_wdata_i;
          REG_SIZE:  size_q  <= reg_wdata_i;
          REG_RDBLK: rdblk_q <= reg_wdata_i;
          default:   ;  // Status and capture words are read only
        endcase
      end
    end else if (!reg_req_i) begin
      reg_ack_o <= 1'b0;
    end
  end

  // Rising bits of CTRL give pulses one cycle after ack rises
  always_ff @(posedge clk) begin
    if (module_rst) begin
      ctrl_prev     <= '0;
      ctrl.start    <= 1'b0;
      ctrl.soft_rst <= 1'b0;
    end else begin
      ctrl_prev     <= ctrl_q[1:0];
      ctrl.start    <= ctrl_q[CTRL_START_BIT] & ~ctrl_prev[CTRL_START_BIT];
      ctrl.soft_rst <= ctrl_q[CTRL_SRST_BIT] & ~ctrl_prev[CTRL_SRST_BIT];
    end
  end

  assign ctrl.test_size  = size_q;
  assign ctrl.rdblk_base = rdblk_q;

  // Capture window decode
  always_comb begin
    fault_off  = reg_addr_i - REG_FAULT_BASE;
    fault_num  = fault_off / FAULT_WORDS;
    fault_word = fault_off % FAULT_WORDS;
    rdblk_off  = reg_addr_i - REG_RDBLK_BASE;
    rdblk_num  = rdblk_off / RDBLK_WORDS;
    rdblk_word = rdblk_off % RDBLK_WORDS;
    in_fault   = (reg_addr_i >= REG_FAULT_BASE) && (fault_num < REG_ADDR_W'(FAULT_DEPTH));
    in_rdblk   = (reg_addr_i >= REG_RDBLK_BASE) && (rdblk_num < REG_ADDR_W'(RDBLK_DEPTH));
  end

  assign ctrl.rec_idx = in_rdblk ? rdblk_num[REC_IDX_W-1:0] : fault_num[REC_IDX_W-1:0];

  always_comb begin
    rd_mux = '0;  // Unmapped addresses read zero
    case (reg_addr_i)
      REG_CTRL:       rd_mux = ctrl_q;
      REG_SIZE:       rd_mux = size_q;
      REG_RDBLK:      rd_mux = rdblk_q;
      REG_STATUS:     rd_mux = {{(REG_W-3){1'b0}}, ctrl.afull_event, ctrl.fault, ctrl.done};
      REG_FAULT_CNT:  rd_mux = REG_W'(ctrl.fault_cnt);
      REG_AFULL_ADDR: rd_mux = REG_W'(ctrl.afull_addr);
      default: begin
        if (in_fault) begin
          case (fault_word)
            6'd0:    rd_mux = ctrl.fault_rec.data[REG_W-1:0];
            6'd1:    rd_mux = ctrl.fault_rec.data[DATA_W-1:REG_W];
            default: rd_mux = ctrl.fault_rec.beat_idx;
          endcase
        end else if (in_rdblk) begin
          rd_mux = (rdblk_word == '0) ? ctrl.rdblk_rec.data[REG_W-1:0]
                                      : ctrl.rdblk_rec.data[DATA_W-1:REG_W];
        end
      end
    endcase
  end

  // Read data held for the whole acknowledge
  always_ff @(posedge clk) begin
    if (req_new) begin
      reg_rdata_o <= rd_mux;
    end
  end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (module_rst)
    $rose(reg_ack_o) |-> $past(reg_req_i));

endmodule

//--- src/capture_buf.sv
// In-order record store, filled once after each clear and frozen when full
module capture_buf #(
  parameter type entry_t = logic [31:0],
  parameter int  DEPTH   = 4
) (
  input  logic                       clk,
  input  logic                       clear_i,
  input  logic                       wr_i,
  input  entry_t                     entry_i,
  input  logic [$clog2(DEPTH)-1:0]   rd_idx_i,
  output entry_t                     entry_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);
  localparam int CNT_W = $clog2(DEPTH + 1);

  entry_t mem [DEPTH];
  logic   wr_en;

  assign wr_en = wr_i & ~clear_i & (count_o != CNT_W'(DEPTH));  // Later records dropped

  always_ff @(posedge clk) begin
    if (clear_i) begin
      count_o <= '0;
    end else if (wr_en) begin
      count_o <= count_o + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[count_o[$clog2(DEPTH)-1:0]] <= entry_i;
    end
  end

  assign entry_o = mem[rd_idx_i];

endmodule

//--- src/harness_ctrl_if.sv
// Control, status and capture signals between register block, sequencer and checker
interface harness_ctrl_if ();
  import harness_cfg_pkg::*;
  import harness_types_pkg::*;

  logic                   start;       // One-cycle pulses
  logic                   soft_rst;
  logic [ADDR_W-1:0]      test_size;
  logic [BEAT_W-1:0]      rdblk_base;
  logic                   busy_rd;
  logic                   afull_event;
  logic [ADDR_W-1:0]      afull_addr;
  logic                   done;
  logic                   fault;
  logic [FAULT_CNT_W-1:0] fault_cnt;
  fault_rec_t             fault_rec;
  rdblk_rec_t             rdblk_rec;
  logic [REC_IDX_W-1:0]   rec_idx;

  modport regs (
    output start, soft_rst, test_size, rdblk_base, rec_idx,
    input  busy_rd, afull_event, afull_addr, done, fault, fault_cnt, fault_rec, rdblk_rec
  );
  modport seq (
    input  start, soft_rst, test_size, done,
    output busy_rd, afull_event, afull_addr
  );
  modport chk (
    input  start, soft_rst, test_size, rdblk_base, rec_idx, busy_rd,
    output done, fault, fault_cnt, fault_rec, rdblk_rec
  );
endinterface

//--- src/harness_types_pkg.sv
// Harness data types: capture records and the test sequencer states
package harness_types_pkg;

  // One logged mismatch
  typedef struct packed {
    logic [harness_cfg_pkg::DATA_W-1:0] data;      // Beat as received
    logic [harness_cfg_pkg::BEAT_W-1:0] beat_idx;
  } fault_rec_t;

  // One beat of the read-block window
  typedef struct packed {
    logic [harness_cfg_pkg::DATA_W-1:0] data;
  } rdblk_rec_t;

  typedef enum logic [2:0] {
    IDLE,
    WR_BEAT0,    // Address and first data beat
    WR_BEAT1,    // Second data beat only
    WR_BACKOFF,
    TURNAROUND,
    RD_ISSUE,
    RD_BACKOFF,
    WAIT_DATA    // All reads issued, beats still returning
  } seq_state_t;

endpackage

//--- src/harness_cfg_pkg.sv
// Harness configuration: datapath widths, capture depths and the register map
package harness_cfg_pkg;

  localparam int ADDR_W     = 16;          // Memory address, counted in addresses
  localparam int DATA_W     = 32;          // One beat
  localparam int BEAT_W     = 16;          // Beat index, repeated twice per beat
  localparam int BEAT_CNT_W = ADDR_W + 1;  // Two beats per address
  localparam int REG_W      = 16;
  localparam int REG_ADDR_W = 6;

  localparam int FAULT_DEPTH = 4;
  localparam int RDBLK_DEPTH = 4;
  localparam int FAULT_CNT_W = $clog2(FAULT_DEPTH + 1);
  // Record index shared by the fault log and the read block
  localparam int REC_IDX_W   = $clog2(FAULT_DEPTH);

  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_SRST_BIT  = 1;

  // Register map, word addresses
  localparam logic [REG_ADDR_W-1:0] REG_CTRL       = 6'd0;
  localparam logic [REG_ADDR_W-1:0] REG_SIZE       = 6'd1;   // Test size in addresses
  localparam logic [REG_ADDR_W-1:0] REG_RDBLK      = 6'd2;   // First beat of read-block window
  localparam logic [REG_ADDR_W-1:0] REG_STATUS     = 6'd3;   // [0] done [1] fault [2] afull
  localparam logic [REG_ADDR_W-1:0] REG_FAULT_CNT  = 6'd4;
  localparam logic [REG_ADDR_W-1:0] REG_AFULL_ADDR = 6'd5;
  localparam logic [REG_ADDR_W-1:0] REG_FAULT_BASE = 6'd8;

  // Data low, data high, beat index
  localparam logic [REG_ADDR_W-1:0] FAULT_WORDS    = 6'd3;
  localparam logic [REG_ADDR_W-1:0] REG_RDBLK_BASE = 6'd20;
  localparam logic [REG_ADDR_W-1:0] RDBLK_WORDS    = 6'd2;   // Data low, data high

endpackage
